//--- source/cplx_defs.svh
`ifndef CPLX_DEFS_SVH
`define CPLX_DEFS_SVH

// Bus widths shared by the sequencer, the engine and the memory ports
`define CPLX_AW 16 // Byte address
`define CPLX_DW 32 // Data word

// Engine operand element
`define CPLX_EW 16

// Interrupt lines seen by the sequencer
`define CPLX_NIRQ 8

// Line carrying the engine done event
`define CPLX_EVT_IRQ 3

// Entries per stream FIFO, both command and operand FIFOs
`define CPLX_FIFO_DEPTH 2

`endif

//--- source/cplx_pkg.sv
`include "cplx_defs.svh"

package cplx_pkg;

  // Memory port request, one-cycle strobe
  typedef struct packed {
    logic                valid;
    logic                we;
    logic [`CPLX_AW-1:0] addr;
    logic [`CPLX_DW-1:0] wdata;
  } mem_req_t;

  // Read data returns exactly one cycle after the request
  typedef struct packed {
    logic                rvalid;
    logic [`CPLX_DW-1:0] rdata;
  } mem_rsp_t;

  // Register port into the engine register block
  typedef struct packed {
    logic                we;
    logic [3:0]          idx;
    logic [`CPLX_DW-1:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic [`CPLX_DW-1:0] rdata; // Addressed register, combinational
  } reg_rsp_t;

  typedef enum logic [3:0] {
    HALT      = 4'd0,
    WRITE_REG = 4'd1,
    WAIT_IRQ  = 4'd2,
    STORE_REG = 4'd3
  } cmd_op_e;

  // Command word layout, op in the top nibble
  typedef struct packed {
    cmd_op_e     op;
    logic [3:0]  idx;
    logic [7:0]  rsvd;
    logic [15:0] imm;
  } cmd_word_t;

endpackage

//--- source/mac_pkg.sv
`include "cplx_defs.svh"

package mac_pkg;

  typedef logic signed [`CPLX_EW-1:0] elem_t; // Operand element
  typedef logic signed [`CPLX_DW-1:0] acc_t;  // Accumulator, wraps

  // Job configuration, all addresses in bytes
  typedef struct packed {
    logic [`CPLX_AW-1:0] src_a;
    logic [`CPLX_AW-1:0] src_b;
    logic [`CPLX_AW-1:0] dst;
    logic [`CPLX_AW-1:0] len;   // Number of element pairs
  } mac_job_t;

  // Register block indices
  typedef enum logic [3:0] {
    SRC_A    = 4'd0,
    SRC_B    = 4'd1,
    DST      = 4'd2,
    LEN      = 4'd3,
    START    = 4'd4, // Write only
    DONE_CNT = 4'd5  // Read only
  } reg_idx_e;

endpackage

//--- source/complex_clock_ctrl.sv
module complex_clock_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic test_mode_i,
  input  logic fetch_en_i,
  output logic gclk_o
);

  logic en_q;
  logic en_latch;

  // Registered fetch enable
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      en_q <= 1'b0;
    end else begin
      en_q <= fetch_en_i;
    end
  end

  // Transparent while clk_i is low, so the enable settles before the next high phase
  always_latch begin
    if (!clk_i) begin
      en_latch = en_q | test_mode_i; // Test mode keeps the clock running
    end
  end

  assign gclk_o = clk_i & en_latch;

endmodule

//--- source/stream_fifo.sv
`include "cplx_defs.svh"

module stream_fifo #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic push_i,
  input  T     data_i,
  input  logic pop_i,
  output T     data_o,
  output logic empty_o,
  output logic full_o
);

  localparam int unsigned Depth = `CPLX_FIFO_DEPTH;
  localparam int unsigned PtrW  = (Depth > 1) ? $clog2(Depth) : 1;

  T                mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [PtrW:0]   count_q;

  // Wrap at Depth, which need not be a power of two
  function automatic logic [PtrW-1:0] ptr_inc(logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == (PtrW + 1)'(Depth));
  assign data_o  = mem_q[rd_ptr_q]; // Head shown while not empty

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop_i) rd_ptr_q <= ptr_inc(rd_ptr_q);
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_ptr_q] <= data_i;
  end

  // The producer and consumer must respect the flags
  flow_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(push_i && full_o) && !(pop_i && empty_o))
    else $error("FIFO overflow or underflow");

endmodule

//--- source/cmd_sequencer.sv
`include "cplx_defs.svh"

module cmd_sequencer
  import cplx_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic [`CPLX_AW-1:0]           boot_addr_i,
  input  logic [`CPLX_NIRQ-1:0]         irq_i,
  input  logic                          evt_i,
  output mem_req_t                      inst_req_o,
  input  mem_rsp_t                      inst_rsp_i,
  output mem_req_t                      data_req_o,
  input  mem_rsp_t                      data_rsp_i,
  output reg_req_t                      reg_req_o,
  input  reg_rsp_t                      reg_rsp_i,
  output logic [$clog2(`CPLX_NIRQ)-1:0] irq_id_o,
  output logic                          irq_ack_o
);

  localparam int unsigned Depth  = `CPLX_FIFO_DEPTH;
  localparam int unsigned NIrq   = `CPLX_NIRQ;
  localparam int unsigned IdW    = $clog2(NIrq);
  localparam int unsigned EvtIrq = `CPLX_EVT_IRQ;
  localparam int unsigned Aw     = `CPLX_AW;
  localparam int unsigned Dw     = `CPLX_DW;

  typedef enum logic [1:0] {
    SEQ_RUN,
    SEQ_WAIT,
    SEQ_HALT
  } seq_state_e;

  seq_state_e             state_q;
  cmd_word_t              fetch_word;
  cmd_word_t              head;
  logic                   fifo_empty;
  logic                   pop;
  logic                   issue;
  logic                   halt_fetched;
  logic [$clog2(Depth):0] credit_q;     // FIFO entries plus fetches in flight
  logic [Aw-1:0]          fetch_off_q;
  logic                   fetch_stop_q;
  mem_req_t               inst_req_q;
  mem_req_t               data_req_q;
  logic                   evt_pend_q;
  logic [NIrq-1:0]        pend;
  logic [IdW-1:0]         low_id;
  logic                   ack_q;
  logic [IdW-1:0]         ack_id_q;

  assign fetch_word   = cmd_word_t'(inst_rsp_i.rdata);
  assign halt_fetched = inst_rsp_i.rvalid && (fetch_word.op == HALT);
  assign pop          = (state_q == SEQ_RUN) && !fifo_empty;
  assign issue        = !fetch_stop_q && !halt_fetched && ((credit_q < Depth) || pop);

  stream_fifo #(
    .T       ( cmd_word_t        )
  ) i_cmd_fifo (
    .clk_i   ( clk_i             ),
    .rst_ni  ( rst_ni            ),
    .push_i  ( inst_rsp_i.rvalid ),
    .data_i  ( fetch_word        ),
    .pop_i   ( pop               ),
    .data_o  ( head              ),
    .empty_o ( fifo_empty        ),
    .full_o  (                   )
  );

  // Register writes and reads go straight from the FIFO head
  assign reg_req_o.we    = pop && (head.op == WRITE_REG);
  assign reg_req_o.idx   = head.idx;
  assign reg_req_o.wdata = Dw'(head.imm);

  // Pending lines, lowest index wins
  always_comb begin
    pend         = irq_i;
    pend[EvtIrq] = irq_i[EvtIrq] | evt_pend_q;
    low_id       = '0;
    for (int i = NIrq - 1; i >= 0; i--) begin
      if (pend[i]) low_id = IdW'(i);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= SEQ_RUN;
      credit_q     <= '0;
      fetch_off_q  <= '0;
      fetch_stop_q <= 1'b0;
      inst_req_q   <= '0;
      data_req_q   <= '0;
      evt_pend_q   <= 1'b0;
      ack_q        <= 1'b0;
      ack_id_q     <= '0;
    end else begin
      inst_req_q.valid <= issue;
      if (issue) begin
        inst_req_q.addr <= boot_addr_i + fetch_off_q;
        fetch_off_q     <= fetch_off_q + Aw'(4);
      end
      if (halt_fetched) fetch_stop_q <= 1'b1; // Nothing past HALT
      if (issue && !pop) begin
        credit_q <= credit_q + 1'b1;
      end else if (pop && !issue) begin
        credit_q <= credit_q - 1'b1;
      end

      data_req_q.valid <= 1'b0;
      ack_q            <= 1'b0;
      evt_pend_q       <= evt_pend_q | evt_i;

      case (state_q)
        SEQ_RUN: begin
          if (pop) begin
            case (head.op)
              HALT:     state_q <= SEQ_HALT;
              WAIT_IRQ: state_q <= SEQ_WAIT;
              STORE_REG: begin
                data_req_q.valid <= 1'b1;
                data_req_q.we    <= 1'b1;
                data_req_q.addr  <= Aw'(head.imm);
                data_req_q.wdata <= reg_rsp_i.rdata;
              end
              default: ; // WRITE_REG goes out on the register port
            endcase
          end
        end
        SEQ_WAIT: begin
          if (|pend) begin
            ack_q    <= 1'b1;
            ack_id_q <= low_id;
            state_q  <= SEQ_RUN;
            // A new event in the same cycle stays pending
            if (low_id == IdW'(EvtIrq)) evt_pend_q <= evt_i;
          end
        end
        default: ; // Halted until reset
      endcase
    end
  end

  assign inst_req_o = inst_req_q;
  assign data_req_o = data_req_q;
  assign irq_ack_o  = ack_q;
  assign irq_id_o   = ack_id_q;

  // The named line was the lowest one pending when the wait resolved
  ack_pending_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_ack_o |-> (($past(pend) & (~$past(pend) + 1'b1)) == (NIrq'(1) << irq_id_o)))
    else $error("irq_ack_o without its line pending as the lowest");

  // Data port only stores, so the memory never answers it
  data_write_only_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !data_rsp_i.rvalid)
    else $error("Unexpected read response on the data port");

endmodule

//--- source/mac_regfile.sv
`include "cplx_defs.svh"

module mac_regfile
  import cplx_pkg::*;
  import mac_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  reg_req_t reg_req_i,
  input  logic     busy_i,
  input  logic     done_i,
  output reg_rsp_t reg_rsp_o,
  output mac_job_t job_o,
  output logic     start_o
);

  localparam int unsigned Aw = `CPLX_AW;
  localparam int unsigned Dw = `CPLX_DW;

  mac_job_t      job_q;
  logic [Dw-1:0] done_cnt_q;
  logic          start_q;
  reg_idx_e      idx;
  logic          start_wr;

  assign idx      = reg_idx_e'(reg_req_i.idx);
  assign start_wr = reg_req_i.we && (idx == START);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      job_q      <= '0;
      done_cnt_q <= '0;
      start_q    <= 1'b0;
    end else begin
      // Dropped while a job runs or is just being launched
      start_q <= start_wr && !busy_i && !start_q;
      if (done_i) done_cnt_q <= done_cnt_q + 1'b1;
      if (reg_req_i.we) begin
        case (idx)
          SRC_A:   job_q.src_a <= Aw'(reg_req_i.wdata);
          SRC_B:   job_q.src_b <= Aw'(reg_req_i.wdata);
          DST:     job_q.dst   <= Aw'(reg_req_i.wdata);
          LEN:     job_q.len   <= Aw'(reg_req_i.wdata);
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (idx)
      SRC_A:    reg_rsp_o.rdata = Dw'(job_q.src_a);
      SRC_B:    reg_rsp_o.rdata = Dw'(job_q.src_b);
      DST:      reg_rsp_o.rdata = Dw'(job_q.dst);
      LEN:      reg_rsp_o.rdata = Dw'(job_q.len);
      DONE_CNT: reg_rsp_o.rdata = done_cnt_q;
      default:  reg_rsp_o.rdata = '0; // START reads as zero
    endcase
  end

  assign job_o   = job_q;
  assign start_o = start_q;

endmodule

//--- source/mac_engine.sv
`include "cplx_defs.svh"

module mac_engine
  import cplx_pkg::*;
  import mac_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  mac_job_t job_i,
  input  logic     start_i,
  input  mem_rsp_t mem_rsp_i,
  output mem_req_t mem_req_o,
  output logic     busy_o,
  output logic     done_o
);

  localparam int unsigned Aw = `CPLX_AW;
  localparam int unsigned Ew = `CPLX_EW;

  logic          busy_q;
  logic          issuing_q;
  logic          phase_b_q;  // Next read targets B
  logic          done_q;
  logic          tag_b_q;    // Describes the read now on the bus
  logic          tag_hi_q;
  logic          rsp_b_q;    // Describes the response now arriving
  logic          rsp_hi_q;
  logic [Aw-1:0] a_addr_q;
  logic [Aw-1:0] b_addr_q;
  logic [Aw-1:0] dst_q;
  logic [Aw-1:0] len_q;
  logic [Aw-1:0] issue_cnt_q;
  logic [Aw-1:0] prod_cnt_q;
  acc_t          acc_q;
  acc_t          acc_next;
  mem_req_t      req_q;
  logic [Aw-1:0] rd_addr;
  logic          a_push;
  logic          b_hit;
  logic          last;
  elem_t         rsp_elem;
  elem_t         a_elem;

  assign rd_addr  = phase_b_q ? b_addr_q : a_addr_q;
  assign rsp_elem = rsp_hi_q ? elem_t'(mem_rsp_i.rdata[2*Ew-1:Ew])
                             : elem_t'(mem_rsp_i.rdata[Ew-1:0]);
  assign a_push   = mem_rsp_i.rvalid && !rsp_b_q;
  assign b_hit    = mem_rsp_i.rvalid && rsp_b_q;
  assign acc_next = acc_q + acc_t'(a_elem) * acc_t'(rsp_elem);
  assign last     = b_hit && (prod_cnt_q + 1'b1 == len_q);

  // A operands wait here for their B partner
  stream_fifo #(
    .T       ( elem_t   )
  ) i_a_fifo (
    .clk_i   ( clk_i    ),
    .rst_ni  ( rst_ni   ),
    .push_i  ( a_push   ),
    .data_i  ( rsp_elem ),
    .pop_i   ( b_hit    ),
    .data_o  ( a_elem   ),
    .empty_o (          ),
    .full_o  (          )
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      issuing_q   <= 1'b0;
      phase_b_q   <= 1'b0;
      done_q      <= 1'b0;
      tag_b_q     <= 1'b0;
      tag_hi_q    <= 1'b0;
      rsp_b_q     <= 1'b0;
      rsp_hi_q    <= 1'b0;
      issue_cnt_q <= '0;
      prod_cnt_q  <= '0;
      req_q       <= '0;
    end else begin
      req_q.valid <= 1'b0;
      done_q      <= 1'b0;
      rsp_b_q     <= tag_b_q;
      rsp_hi_q    <= tag_hi_q;
      if (start_i) begin
        phase_b_q   <= 1'b0;
        issue_cnt_q <= '0;
        prod_cnt_q  <= '0;
        if (job_i.len == '0) begin // Empty job writes zero at once
          req_q  <= '{valid: 1'b1, we: 1'b1, addr: job_i.dst, wdata: '0};
          done_q <= 1'b1;
        end else begin
          busy_q    <= 1'b1;
          issuing_q <= 1'b1;
        end
      end else begin
        if (issuing_q) begin
          req_q     <= '{valid: 1'b1, we: 1'b0, addr: rd_addr, wdata: '0};
          tag_b_q   <= phase_b_q;
          tag_hi_q  <= rd_addr[1];
          phase_b_q <= !phase_b_q;
          if (phase_b_q) begin
            issue_cnt_q <= issue_cnt_q + 1'b1;
            if (issue_cnt_q + 1'b1 == len_q) issuing_q <= 1'b0;
          end
        end
        if (b_hit) begin
          prod_cnt_q <= prod_cnt_q + 1'b1;
          if (last) begin // Result write and done share a cycle
            req_q  <= '{valid: 1'b1, we: 1'b1, addr: dst_q, wdata: acc_next};
            done_q <= 1'b1;
            busy_q <= 1'b0;
          end
        end
      end
    end
  end

  // Job addresses and the running sum
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      a_addr_q <= job_i.src_a;
      b_addr_q <= job_i.src_b;
      dst_q    <= job_i.dst;
      len_q    <= job_i.len;
      acc_q    <= '0;
    end else begin
      if (issuing_q && !phase_b_q) a_addr_q <= a_addr_q + Aw'(Ew / 8);
      if (issuing_q && phase_b_q) b_addr_q <= b_addr_q + Aw'(Ew / 8);
      if (b_hit) acc_q <= acc_next;
    end
  end

  assign mem_req_o = req_q;
  assign busy_o    = busy_q;
  assign done_o    = done_q;

  // The register block must hold back a START while a job runs
  start_idle_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_i |-> !busy_q)
    else $error("Engine started while busy");

endmodule

//--- source/mac_complex.sv
`include "cplx_defs.svh"

module mac_complex
  import cplx_pkg::*;
  import mac_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          test_mode_i,
  input  logic                          fetch_en_i,
  input  logic [`CPLX_AW-1:0]           boot_addr_i,
  input  logic [`CPLX_NIRQ-1:0]         irq_i,
  output logic [$clog2(`CPLX_NIRQ)-1:0] irq_id_o,
  output logic                          irq_ack_o,
  output mem_req_t                      inst_req_o,
  input  mem_rsp_t                      inst_rsp_i,
  output mem_req_t                      data_req_o,
  input  mem_rsp_t                      data_rsp_i,
  output mem_req_t                      accel_req_o,
  input  mem_rsp_t                      accel_rsp_i
);

  logic     gclk;
  reg_req_t reg_req;
  reg_rsp_t reg_rsp;
  mac_job_t job;
  logic     start;
  logic     busy;
  logic     evt;   // Engine done, also interrupt line 3

  complex_clock_ctrl i_clock_ctrl (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .test_mode_i ( test_mode_i ),
    .fetch_en_i  ( fetch_en_i  ),
    .gclk_o      ( gclk        )
  );

  cmd_sequencer i_sequencer (
    .clk_i       ( gclk        ),
    .rst_ni      ( rst_ni      ),
    .boot_addr_i ( boot_addr_i ),
    .irq_i       ( irq_i       ),
    .evt_i       ( evt         ),
    .inst_req_o  ( inst_req_o  ),
    .inst_rsp_i  ( inst_rsp_i  ),
    .data_req_o  ( data_req_o  ),
    .data_rsp_i  ( data_rsp_i  ),
    .reg_req_o   ( reg_req     ),
    .reg_rsp_i   ( reg_rsp     ),
    .irq_id_o    ( irq_id_o    ),
    .irq_ack_o   ( irq_ack_o   )
  );

  mac_regfile i_regfile (
    .clk_i     ( gclk    ),
    .rst_ni    ( rst_ni  ),
    .reg_req_i ( reg_req ),
    .busy_i    ( busy    ),
    .done_i    ( evt     ),
    .reg_rsp_o ( reg_rsp ),
    .job_o     ( job     ),
    .start_o   ( start   )
  );

  mac_engine i_engine (
    .clk_i     ( gclk        ),
    .rst_ni    ( rst_ni      ),
    .job_i     ( job         ),
    .start_i   ( start       ),
    .mem_rsp_i ( accel_rsp_i ),
    .mem_req_o ( accel_req_o ),
    .busy_o    ( busy        ),
    .done_o    ( evt         )
  );

endmodule

//--- test/tb_mem_model.sv
`include "cplx_defs.svh"

module tb_mem_model
  import cplx_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  mem_req_t inst_req_i,
  output mem_rsp_t inst_rsp_o,
  input  mem_req_t data_req_i,
  output mem_rsp_t data_rsp_o,
  input  mem_req_t accel_req_i,
  output mem_rsp_t accel_rsp_o
);

  localparam int unsigned Words  = 1 << (`CPLX_AW - 2);
  localparam int unsigned NPorts = 3;

  logic [`CPLX_DW-1:0] mem_q [Words]; // Also loaded and read by the testbench
  mem_req_t            req [NPorts];
  mem_rsp_t            rsp_q [NPorts];

  assign req[0]      = inst_req_i;
  assign req[1]      = data_req_i;
  assign req[2]      = accel_req_i;
  assign inst_rsp_o  = rsp_q[0];
  assign data_rsp_o  = rsp_q[1];
  assign accel_rsp_o = rsp_q[2];

  // Every word differs with its whole address
  initial begin
    for (int i = 0; i < Words; i++) begin
      mem_q[i] = {~i[15:0], i[15:0]};
    end
  end

  // Read data exactly one cycle after the strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int p = 0; p < NPorts; p++) begin
        rsp_q[p] <= '0;
      end
    end else begin
      for (int p = 0; p < NPorts; p++) begin
        rsp_q[p].rvalid <= req[p].valid && !req[p].we;
        rsp_q[p].rdata  <= '0;
        if (req[p].valid && !req[p].we) begin
          rsp_q[p].rdata <= mem_q[req[p].addr[`CPLX_AW-1:2]];
        end
      end
    end
  end

  always @(posedge clk_i) begin
    for (int p = 0; p < NPorts; p++) begin
      if (req[p].valid && req[p].we) begin
        mem_q[req[p].addr[`CPLX_AW-1:2]] <= req[p].wdata; // No response for writes
      end
    end
  end

endmodule

//--- test/tb_mac_complex.sv
`include "cplx_defs.svh"

module tb_mac_complex
  import cplx_pkg::*;
  import mac_pkg::*;
();

  localparam int                  NRows     = 5;
  localparam int                  WaitLimit = 1000; // Cycles allowed per wait
  localparam int                  IdW       = $clog2(`CPLX_NIRQ);
  localparam logic [`CPLX_AW-1:0] BootAddr  = 16'h0100;

  typedef struct packed {
    logic [`CPLX_AW-1:0] len;
    logic [`CPLX_AW-1:0] src_a;
    logic [`CPLX_AW-1:0] src_b;
    logic [`CPLX_AW-1:0] dst;
    logic [`CPLX_AW-1:0] status;  // DONE_CNT lands here
    logic                ext_irq; // Line 1 raised before the wait
    logic                restart; // Second START while busy
  } job_row_t;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  test_mode;
  logic                  fetch_en;
  logic [`CPLX_AW-1:0]   boot_addr;
  logic [`CPLX_NIRQ-1:0] irq;
  logic [IdW-1:0]        irq_id;
  logic                  irq_ack;
  mem_req_t              inst_req;
  mem_rsp_t              inst_rsp;
  mem_req_t              data_req;
  mem_rsp_t              data_rsp;
  mem_req_t              accel_req;
  mem_rsp_t              accel_rsp;
  job_row_t              jobs [NRows];
  logic [31:0]           exp_sum [NRows];
  logic [31:0]           lfsr_q;

  always #5 clk = ~clk;

  mac_complex uut (
    .clk_i       ( clk       ),
    .rst_ni      ( rst_n     ),
    .test_mode_i ( test_mode ),
    .fetch_en_i  ( fetch_en  ),
    .boot_addr_i ( boot_addr ),
    .irq_i       ( irq       ),
    .irq_id_o    ( irq_id    ),
    .irq_ack_o   ( irq_ack   ),
    .inst_req_o  ( inst_req  ),
    .inst_rsp_i  ( inst_rsp  ),
    .data_req_o  ( data_req  ),
    .data_rsp_i  ( data_rsp  ),
    .accel_req_o ( accel_req ),
    .accel_rsp_i ( accel_rsp )
  );

  tb_mem_model i_mem (
    .clk_i       ( clk       ),
    .rst_ni      ( rst_n     ),
    .inst_req_i  ( inst_req  ),
    .inst_rsp_o  ( inst_rsp  ),
    .data_req_i  ( data_req  ),
    .data_rsp_o  ( data_rsp  ),
    .accel_req_i ( accel_req ),
    .accel_rsp_o ( accel_rsp )
  );

  task automatic stop_failed();
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("ERR %0t: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
    stop_failed();
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout after %0d cycles waiting for %s", WaitLimit, what);
    stop_failed();
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [15:0] take_bits16();
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < 16; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[14:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] get_word(input logic [`CPLX_AW-1:0] addr);
    return i_mem.mem_q[addr[`CPLX_AW-1:2]];
  endfunction

  task automatic put_word(input logic [`CPLX_AW-1:0] addr, input logic [31:0] data);
    i_mem.mem_q[addr[`CPLX_AW-1:2]] = data;
  endtask

  task automatic put_half(input logic [`CPLX_AW-1:0] addr, input logic [15:0] val);
    logic [31:0] w;
    w = get_word(addr);
    if (addr[1]) begin
      w[31:16] = val; // Upper half at byte offset 2
    end else begin
      w[15:0] = val;
    end
    put_word(addr, w);
  endtask

  // Command word: op, idx, reserved byte, imm
  task automatic emit_cmd(inout logic [`CPLX_AW-1:0] pc, input logic [3:0] op,
                          input logic [3:0] idx, input logic [15:0] imm);
    put_word(pc, {op, idx, 8'h00, imm});
    pc = pc + 16'd4;
  endtask

  task automatic set_job(input int r, input int len, input logic [15:0] a,
                         input logic [15:0] b, input logic [15:0] dst,
                         input logic [15:0] status, input logic ext, input logic restart);
    jobs[r] = '{len: 16'(len), src_a: a, src_b: b, dst: dst, status: status,
                ext_irq: ext, restart: restart};
  endtask

  // Operands, expected sums and one program segment per row
  task automatic build_jobs();
    logic [`CPLX_AW-1:0] pc;
    logic signed [15:0]  a_val;
    logic signed [15:0]  b_val;
    logic signed [31:0]  acc;
    pc = BootAddr;
    for (int r = 0; r < NRows; r++) begin
      acc = '0;
      for (int k = 0; k < jobs[r].len; k++) begin
        a_val = take_bits16();
        b_val = take_bits16();
        put_half(jobs[r].src_a + 16'(2 * k), a_val);
        put_half(jobs[r].src_b + 16'(2 * k), b_val);
        acc = acc + a_val * b_val; // Wraps at 32 bits
      end
      exp_sum[r] = acc;
      emit_cmd(pc, WRITE_REG, SRC_A, jobs[r].src_a);
      emit_cmd(pc, WRITE_REG, SRC_B, jobs[r].src_b);
      emit_cmd(pc, WRITE_REG, DST, jobs[r].dst);
      emit_cmd(pc, WRITE_REG, LEN, jobs[r].len);
      emit_cmd(pc, WRITE_REG, START, 16'h0);
      if (jobs[r].restart) emit_cmd(pc, WRITE_REG, START, 16'h0);
      emit_cmd(pc, WAIT_IRQ, 4'h0, 16'h0);
      if (jobs[r].ext_irq) emit_cmd(pc, WAIT_IRQ, 4'h0, 16'h0); // Picks up the event
      emit_cmd(pc, STORE_REG, DONE_CNT, jobs[r].status);
    end
    emit_cmd(pc, HALT, 4'h0, 16'h0);
  endtask

  task automatic wait_ack(output logic [IdW-1:0] id);
    int n;
    n  = 0;
    id = '0;
    do begin
      @(posedge clk);
      n++;
    end while (!irq_ack && n < WaitLimit);
    if (!irq_ack) begin
      report_timeout("irq_ack_o");
    end else begin
      id = irq_id;
    end
  endtask

  task automatic wait_store(input logic [`CPLX_AW-1:0] addr, output logic [31:0] wdata);
    int   n;
    logic hit;
    n     = 0;
    hit   = 1'b0;
    wdata = '0;
    while (!hit && n < WaitLimit) begin
      @(posedge clk);
      n++;
      hit = data_req.valid && data_req.we && (data_req.addr == addr);
    end
    if (!hit) begin
      report_timeout($sformatf("a store to 0x%0h", addr));
    end else begin
      wdata = data_req.wdata;
    end
  endtask

  initial begin
    logic [IdW-1:0] id;
    logic [31:0]    wdata;
    rst_n     = 1'b0;
    test_mode = 1'b0;
    fetch_en  = 1'b0;
    boot_addr = BootAddr;
    irq       = '0;
    lfsr_q    = 32'h4b00;

    //      row len src_a    src_b    dst      status   ext   restart
    set_job(0,  4,  16'h1000, 16'h1100, 16'h2000, 16'h2004, 1'b0, 1'b0);
    set_job(1,  0,  16'h1200, 16'h1300, 16'h2010, 16'h2014, 1'b0, 1'b0);
    set_job(2,  7,  16'h1402, 16'h1500, 16'h2020, 16'h2024, 1'b1, 1'b0);
    set_job(3,  5,  16'h1600, 16'h1702, 16'h2030, 16'h2034, 1'b0, 1'b1);
    set_job(4,  16, 16'h1800, 16'h1900, 16'h2040, 16'h2044, 1'b0, 1'b0);

    repeat (10) @(posedge clk);
    build_jobs();
    rst_n <= 1'b1;

    // Gated clock off, so no fetch may start
    repeat (20) begin
      @(posedge clk);
      assert (!inst_req.valid)
        else report_mismatch("inst request with fetch disabled", 32'(inst_req.valid), 32'd0);
    end
    fetch_en <= 1'b1;

    for (int r = 0; r < NRows; r++) begin
      if (jobs[r].ext_irq) begin
        irq[1] <= 1'b1;
        wait_ack(id);
        assert (id == IdW'(1))
          else report_mismatch($sformatf("row %0d first irq_id_o", r), 32'(id), 32'd1);
        irq[1] <= 1'b0;
      end
      wait_ack(id);
      assert (id == IdW'(`CPLX_EVT_IRQ))
        else report_mismatch($sformatf("row %0d irq_id_o", r), 32'(id), `CPLX_EVT_IRQ);
      wait_store(jobs[r].status, wdata);
      assert (wdata == 32'(r + 1))
        else report_mismatch($sformatf("row %0d stored DONE_CNT", r), wdata, 32'(r + 1));
    end

    repeat (2) @(posedge clk); // Last write reaches memory
    for (int r = 0; r < NRows; r++) begin
      assert (get_word(jobs[r].dst) == exp_sum[r])
        else report_mismatch($sformatf("row %0d dot product", r), get_word(jobs[r].dst),
                             exp_sum[r]);
      assert (get_word(jobs[r].status) == 32'(r + 1))
        else report_mismatch($sformatf("row %0d status word", r), get_word(jobs[r].status),
                             32'(r + 1));
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- compile.f
+incdir+source
source/cplx_pkg.sv
source/mac_pkg.sv
source/complex_clock_ctrl.sv
source/stream_fifo.sv
source/cmd_sequencer.sv
source/mac_regfile.sv
source/mac_engine.sv
source/mac_complex.sv
test/tb_mem_model.sv
test/tb_mac_complex.sv

//--- Bender.yml
package:
  name: mac_complex

export_include_dirs:
  - source

sources:
  - source/cplx_pkg.sv
  - source/mac_pkg.sv
  - source/complex_clock_ctrl.sv
  - source/stream_fifo.sv
  - source/cmd_sequencer.sv
  - source/mac_regfile.sv
  - source/mac_engine.sv
  - source/mac_complex.sv
  - target: test
    files:
      - test/tb_mem_model.sv
      - test/tb_mac_complex.sv
